//--- Bender.yml
package:
  name: video_top

sources:
  - logic/video_regs_pkg.sv
  - logic/video_raster_pkg.sv
  - logic/video_ports.sv
  - logic/video_raster.sv
  - logic/video_dpram.sv
  - logic/video_tsline.sv
  - logic/video_mixer.sv
  - logic/video_palette.sv
  - logic/video_top.sv
  - target: simulation
    files:
      - verification/video_top_tb.sv

//--- logic/video_dpram.sv
`timescale 1ns/1ps

module video_dpram #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 5
) (
  input  logic                  clk,
  input  logic                  we,
  input  logic [ADDR_WIDTH-1:0] waddr,
  input  logic [DATA_WIDTH-1:0] wdata,
  input  logic [ADDR_WIDTH-1:0] raddr,
  output logic [DATA_WIDTH-1:0] rdata
);

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  always_ff @(posedge clk)
  begin
    if (we)
      mem[waddr] <= wdata;
    // same address in one clock returns the old word
    rdata <= mem[raddr];
  end

endmodule

//--- logic/video_mixer.sv
`timescale 1ns/1ps

module video_mixer
  import video_regs_pkg::*;
  import video_raster_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  raster_t    raster_in,
  input  color_idx_t ts_pix,
  input  color_idx_t border,
  input  logic       notsu,
  output raster_t    raster_out,
  output color_idx_t mix_idx
);

  // flags lined up with ts_pix
  raster_t raster_d;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      raster_d   <= '0;
      raster_out <= '0;
    end
    else
    begin
      raster_d   <= raster_in;
      raster_out <= raster_d;
    end
  end

  // overlay wins unless transparent or hidden
  always_ff @(posedge clk)
  begin
    if (raster_d.active && (ts_pix != '0) && !notsu)
      mix_idx <= ts_pix;
    else
      mix_idx <= border;
  end

endmodule

//--- logic/video_palette.sv
`timescale 1ns/1ps

module video_palette
  import video_regs_pkg::*;
  import video_raster_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  cram_wr_t   cram_wr,
  input  color_idx_t idx,
  input  raster_t    raster,
  output logic [4:0] red,
  output logic [4:0] grn,
  output logic [4:0] blu,
  output logic       hsync,
  output logic       vsync,
  output logic       blank
);

  // colour ram, one entry per index
  rgb_t cram [2**$bits(color_idx_t)];
  rgb_t rgb;

  always_ff @(posedge clk)
  begin
    if (cram_wr.stb)
      cram[cram_wr.addr] <= cram_wr.rgb;
  end

  // lookup and syncs leave on the same clock
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rgb   <= '0;
      hsync <= 1'b0;
      vsync <= 1'b0;
      blank <= 1'b1;
    end
    else
    begin
      hsync <= raster.hsync;
      vsync <= raster.vsync;
      blank <= !raster.active;
      // black outside the window
      if (raster.active)
        rgb <= cram[idx];
      else
        rgb <= '0;
    end
  end

  assign red = rgb[14:10];
  assign grn = rgb[9:5];
  assign blu = rgb[4:0];

endmodule

//--- logic/video_ports.sv
`timescale 1ns/1ps

module video_ports
  import video_regs_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  port_wr_t   port_wr,
  input  logic       line_start,
  output color_idx_t border,
  output logic       notsu
);

  // written by the cpu side
  logic [7:0] vconf_shadow;
  // what the display uses this line
  logic [7:0] vconf;

  logic wr_border;
  logic wr_vconf;

  // address decode
  assign wr_border = port_wr.stb && (port_wr.addr == PORT_BORDER);
  assign wr_vconf  = port_wr.stb && (port_wr.addr == PORT_VCONF);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      border       <= '0;
      vconf_shadow <= '0;
      vconf        <= '0;
    end
    else
    begin
      // border goes live at once
      if (wr_border)
        border <= port_wr.data;
      if (wr_vconf)
        vconf_shadow <= port_wr.data;
      // config only changes between lines
      if (line_start)
        vconf <= vconf_shadow;
    end
  end

  // only the overlay hide bit leaves
  assign notsu = vconf[VCONF_NOTSU_BIT];

endmodule

//--- logic/video_raster.sv
`timescale 1ns/1ps

module video_raster
  import video_raster_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  output raster_t raster,
  output logic    line_odd,
  output xpix_t   rd_x
);

  hcount_t h;
  vcount_t v;
  logic    h_last;
  logic    v_last;
  logic    h_win;
  logic    v_win;

  assign h_last = (h == hcount_t'(H_TOTAL - 1));
  assign v_last = (v == vcount_t'(V_TOTAL - 1));

  // position counters, wrap per line and per frame
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      h <= '0;
      v <= '0;
    end
    else if (h_last)
    begin
      h <= '0;
      if (v_last)
        v <= '0;
      else
        v <= v + 1'b1;
    end
    else
      h <= h + 1'b1;
  end

  // visible window
  assign h_win = (h >= hcount_t'(H_PIX_BEG)) && (h < hcount_t'(H_PIX_END));
  assign v_win = (v >= vcount_t'(V_PIX_BEG)) && (v < vcount_t'(V_PIX_END));

  // flags for the current position, one clock late
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      raster   <= '0;
      line_odd <= 1'b0;
    end
    else
    begin
      raster.hsync      <= (h < hcount_t'(H_SYNC_LEN));
      raster.vsync      <= (v < vcount_t'(V_SYNC_LEN));
      raster.active     <= h_win && v_win;
      raster.line_start <= (h == '0);
      // picks the buffer on screen
      line_odd          <= v[0];
    end
  end

  // line buffer column, meaningless outside the window
  always_ff @(posedge clk)
  begin
    rd_x <= xpix_t'(h - hcount_t'(H_PIX_BEG));
  end

endmodule

//--- logic/video_raster_pkg.sv
package video_raster_pkg;

  import video_regs_pkg::*;

  // clocks per line, sync starts at h = 0
  localparam int H_TOTAL    = 64;
  localparam int H_SYNC_LEN = 4;
  // window columns, end exclusive
  localparam int H_PIX_BEG  = 16;
  localparam int H_PIX_END  = 48;

  // lines per frame, sync starts at v = 0
  localparam int V_TOTAL    = 16;
  localparam int V_SYNC_LEN = 2;
  localparam int V_PIX_BEG  = 4;
  localparam int V_PIX_END  = 12;

  // overlay line buffer depth
  localparam int LINE_PIXELS = 32;

  typedef logic [5:0] hcount_t;
  typedef logic [3:0] vcount_t;
  typedef logic [4:0] xpix_t;

  typedef struct packed {
    logic hsync;
    logic vsync;
    logic active;
    logic line_start;
  } raster_t;

  // one overlay pixel for the next line
  typedef struct packed {
    logic       stb;
    xpix_t      x;
    color_idx_t pix;
  } ts_wr_t;

endpackage

//--- logic/video_regs_pkg.sv
package video_regs_pkg;

  // palette index, zero is transparent in the overlay
  typedef logic [7:0] color_idx_t;

  // 5:5:5 colour, red in the top bits
  typedef logic [14:0] rgb_t;

  typedef logic [7:0] port_addr_t;

  // kept port registers
  localparam port_addr_t PORT_BORDER = 8'h0F;
  localparam port_addr_t PORT_VCONF  = 8'h00;

  // vconf bit that hides the overlay
  localparam int VCONF_NOTSU_BIT = 4;

  typedef struct packed {
    logic       stb;
    port_addr_t addr;
    logic [7:0] data;
  } port_wr_t;

  typedef struct packed {
    logic       stb;
    color_idx_t addr;
    rgb_t       rgb;
  } cram_wr_t;

endpackage

//--- logic/video_top.sv
`timescale 1ns/1ps

module video_top
  import video_regs_pkg::*;
  import video_raster_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  port_wr_t   port_wr,
  input  cram_wr_t   cram_wr,
  input  ts_wr_t     ts_wr,
  output logic [4:0] red,
  output logic [4:0] grn,
  output logic [4:0] blu,
  output logic       hsync,
  output logic       vsync,
  output logic       blank
);

  // raster side
  raster_t    raster;
  logic       line_odd;
  xpix_t      rd_x;
  // register side
  color_idx_t border;
  logic       notsu;
  // pixel path
  color_idx_t ts_pix;
  color_idx_t mix_idx;
  raster_t    mix_raster;

  video_raster i_video_raster (
    .clk      (clk),
    .rst      (rst),
    .raster   (raster),
    .line_odd (line_odd),
    .rd_x     (rd_x)
  );

  video_ports i_video_ports (
    .clk        (clk),
    .rst        (rst),
    .port_wr    (port_wr),
    .line_start (raster.line_start),
    .border     (border),
    .notsu      (notsu)
  );

  // overlay ping-pong buffers
  video_tsline i_video_tsline (
    .clk      (clk),
    .rst      (rst),
    .ts_wr    (ts_wr),
    .line_odd (line_odd),
    .active   (raster.active),
    .rd_x     (rd_x),
    .ts_pix   (ts_pix)
  );

  video_mixer i_video_mixer (
    .clk        (clk),
    .rst        (rst),
    .raster_in  (raster),
    .ts_pix     (ts_pix),
    .border     (border),
    .notsu      (notsu),
    .raster_out (mix_raster),
    .mix_idx    (mix_idx)
  );

  video_palette i_video_palette (
    .clk     (clk),
    .rst     (rst),
    .cram_wr (cram_wr),
    .idx     (mix_idx),
    .raster  (mix_raster),
    .red     (red),
    .grn     (grn),
    .blu     (blu),
    .hsync   (hsync),
    .vsync   (vsync),
    .blank   (blank)
  );

endmodule

//--- logic/video_tsline.sv
`timescale 1ns/1ps

module video_tsline
  import video_regs_pkg::*;
  import video_raster_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  ts_wr_t     ts_wr,
  input  logic       line_odd,
  input  logic       active,
  input  xpix_t      rd_x,
  output color_idx_t ts_pix
);

  logic       line_odd_q;
  color_idx_t rdata [2];

  for (genvar i = 0; i < 2; i++)
  begin : g_buf
    logic       shown;
    logic       we;
    xpix_t      waddr;
    color_idx_t wdata;

    // buffer i is on screen for lines of parity i
    assign shown = (line_odd == 1'(i));

    // on screen it is wiped behind the read
    // off screen it collects the next line
    assign we    = shown ? active : ts_wr.stb;
    assign waddr = shown ? rd_x : ts_wr.x;
    assign wdata = shown ? color_idx_t'(0) : ts_wr.pix;

    video_dpram #(
      .DATA_WIDTH ($bits(color_idx_t)),
      .ADDR_WIDTH ($clog2(LINE_PIXELS))
    ) i_video_dpram (
      .clk   (clk),
      .we    (we),
      .waddr (waddr),
      .wdata (wdata),
      .raddr (rd_x),
      .rdata (rdata[i])
    );
  end

  // parity of the read now in rdata
  always_ff @(posedge clk)
  begin
    if (rst)
      line_odd_q <= 1'b0;
    else
      line_odd_q <= line_odd;
  end

  assign ts_pix = line_odd_q ? rdata[1] : rdata[0];

endmodule

//--- verification/video_top_tb.sv
`timescale 1ns/1ps

module video_top_tb
  import video_regs_pkg::*;
  import video_raster_pkg::*;
();

  localparam int         CLK_HALF   = 2;
  localparam int         RST_CYCLES = 16;
  localparam int         FRAME_CLKS = H_TOTAL * V_TOTAL;
  localparam logic [31:0] SEED      = 32'hd40d;
  localparam color_idx_t BORDER_IDX = 8'h2A;

  // step kinds
  localparam logic [2:0] K_PORT = 3'd0;
  localparam logic [2:0] K_CRAM = 3'd1;
  localparam logic [2:0] K_OVL  = 3'd2;
  localparam logic [2:0] K_WAIT = 3'd3;
  localparam logic [2:0] K_LINE = 3'd4;
  localparam logic [2:0] K_PIX  = 3'd5;

  // a holds the address, column or line and d the data, pixel or column
  typedef struct packed {
    logic [2:0] kind;
    logic [7:0] a;
    logic [7:0] d;
    rgb_t       exp;
  } step_t;

  logic       clk;
  logic       rst;
  port_wr_t   port_wr;
  cram_wr_t   cram_wr;
  ts_wr_t     ts_wr;
  logic [4:0] red;
  logic [4:0] grn;
  logic [4:0] blu;
  logic       hsync;
  logic       vsync;
  logic       blank;

  step_t steps[$];
  // colour ram contents as loaded
  rgb_t  cram_val [256];
  logic  cram_has [256];
  // expected overlay colour per target line and column
  rgb_t  ovl_rgb [V_TOTAL][LINE_PIXELS];
  logic  ovl_set [V_TOTAL][LINE_PIXELS];
  rgb_t  border_rgb;

  // position of the pixel now on the outputs
  int    ox;
  int    oy;
  logic  locked;
  logic  hsync_q;
  logic  vsync_q;

  video_top i_video_top (
    .clk     (clk),
    .rst     (rst),
    .port_wr (port_wr),
    .cram_wr (cram_wr),
    .ts_wr   (ts_wr),
    .red     (red),
    .grn     (grn),
    .blu     (blu),
    .hsync   (hsync),
    .vsync   (vsync),
    .blank   (blank)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #CLK_HALF clk = ~clk;
  end

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "stopping at the first error");
  endtask

  function automatic rgb_t rgb_out();
    return {red, grn, blu};
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("** Error: %s = 0x%0h, expected 0x%0h at line %0d column %0d",
               name, got, exp, oy, ox);
      abort_run();
    end
  endtask

  task automatic check_reset_state();
    check_value("hsync", hsync, 1'b0);
    check_value("vsync", vsync, 1'b0);
    check_value("blank", blank, 1'b1);
    check_value("rgb", rgb_out(), 0);
  endtask

  // one clock then track position and check sync and blank
  task automatic tick();
    logic in_win;
    @(negedge clk);
    if (locked)
    begin
      ox = (ox + 1) % H_TOTAL;
      if (ox == 0)
        oy = (oy + 1) % V_TOTAL;
    end
    else if (vsync && !vsync_q)
    begin
      // frame start where hsync rises on the same pixel
      check_value("hsync rise", hsync && !hsync_q, 1'b1);
      locked = 1'b1;
      ox = 0;
      oy = 0;
    end
    hsync_q = hsync;
    vsync_q = vsync;
    if (locked)
    begin
      in_win = (ox >= H_PIX_BEG) && (ox < H_PIX_END) &&
               (oy >= V_PIX_BEG) && (oy < V_PIX_END);
      check_value("hsync", hsync, ox < H_SYNC_LEN);
      check_value("vsync", vsync, oy < V_SYNC_LEN);
      check_value("blank", blank, !in_win);
      // black outside the window
      if (!in_win)
        check_value("rgb", rgb_out(), 0);
    end
  endtask

  task automatic wait_pos(int line, int col);
    int n;
    n = 0;
    while (!((oy == line) && (ox == col)))
    begin
      tick();
      n++;
      if (n > 2 * FRAME_CLKS)
      begin
        $display("timed out waiting for line %0d column %0d", line, col);
        abort_run();
      end
    end
  endtask

  // whole window of one line with overlay where written and bg elsewhere
  task automatic check_line(int line, rgb_t bg);
    rgb_t exp;
    int   x;
    wait_pos(line, H_PIX_BEG);
    for (x = 0; x < LINE_PIXELS; x++)
    begin
      exp = ovl_set[line][x] ? ovl_rgb[line][x] : bg;
      check_value("rgb", rgb_out(), exp);
      ovl_set[line][x] = 1'b0;
      tick();
    end
  endtask

  // one pixel further along the current line
  task automatic check_pix(int col, rgb_t exp);
    int n;
    n = 0;
    while (ox != col)
    begin
      tick();
      n++;
      if (n > H_TOTAL)
      begin
        $display("timed out waiting for column %0d", col);
        abort_run();
      end
    end
    check_value("rgb", rgb_out(), exp);
  endtask

  task automatic apply_step(step_t s);
    case (s.kind)
      K_PORT:
      begin
        port_wr = {1'b1, s.a, s.d};
        tick();
        port_wr.stb = 1'b0;
      end
      K_CRAM:
      begin
        cram_wr = {1'b1, s.a, s.exp};
        tick();
        cram_wr.stb = 1'b0;
      end
      K_OVL:
      begin
        // shows up on the line after this one
        ovl_rgb[(oy + 1) % V_TOTAL][s.a] = s.exp;
        ovl_set[(oy + 1) % V_TOTAL][s.a] = 1'b1;
        ts_wr = {1'b1, xpix_t'(s.a), s.d};
        tick();
        ts_wr.stb = 1'b0;
      end
      K_WAIT:
        wait_pos(s.a, s.d);
      K_LINE:
        check_line(s.a, s.exp);
      K_PIX:
        check_pix(s.a, s.exp);
      default:
      begin
        $display("unknown step kind %0d", s.kind);
        abort_run();
      end
    endcase
  endtask

  function automatic step_t make_step(logic [2:0] kind, int a, int d, rgb_t exp);
    step_t s;
    s.kind = kind;
    s.a    = 8'(a);
    s.d    = 8'(d);
    s.exp  = exp;
    return s;
  endfunction

  // random nonzero index loaded into the colour ram on first use
  function automatic color_idx_t pick_pix();
    color_idx_t p;
    p = color_idx_t'($urandom_range(255, 1));
    if (!cram_has[p])
    begin
      cram_has[p] = 1'b1;
      cram_val[p] = rgb_t'($urandom_range(32767, 1));
      steps.push_back(make_step(K_CRAM, p, 0, cram_val[p]));
    end
    return p;
  endfunction

  task automatic build_table();
    color_idx_t p6 [4];
    xpix_t      x6 [4];
    color_idx_t p10 [3];
    xpix_t      x10 [3];
    color_idx_t p11 [3];
    xpix_t      x11 [3];
    int         k;
    border_rgb = rgb_t'($urandom_range(32767, 1));
    cram_has[BORDER_IDX] = 1'b1;
    cram_val[BORDER_IDX] = border_rgb;
    steps.push_back(make_step(K_CRAM, BORDER_IDX, 0, border_rgb));
    // distinct columns with one per block of eight
    for (k = 0; k < 4; k++)
    begin
      x6[k] = xpix_t'(8 * k + $urandom_range(7));
      p6[k] = pick_pix();
    end
    // right half only so they land after the mid-line vconf write
    for (k = 0; k < 3; k++)
    begin
      x10[k] = xpix_t'(16 + 5 * k + $urandom_range(4));
      p10[k] = pick_pix();
      x11[k] = xpix_t'($urandom_range(31));
      p11[k] = pick_pix();
    end
    steps.push_back(make_step(K_PORT, PORT_BORDER, BORDER_IDX, 0));
    // skip the first frame window where both buffers get wiped
    steps.push_back(make_step(K_WAIT, V_PIX_END, 0, 0));
    steps.push_back(make_step(K_LINE, 4, 0, border_rgb));
    // overlay for line 6
    steps.push_back(make_step(K_WAIT, 5, 20, 0));
    for (k = 0; k < 4; k++)
      steps.push_back(make_step(K_OVL, x6[k], p6[k], cram_val[p6[k]]));
    steps.push_back(make_step(K_LINE, 6, 0, border_rgb));
    // nothing written and the buffers were cleared on lines 5 and 6
    steps.push_back(make_step(K_LINE, 7, 0, border_rgb));
    steps.push_back(make_step(K_LINE, 8, 0, border_rgb));
    // overlay for line 10
    steps.push_back(make_step(K_WAIT, 9, 20, 0));
    for (k = 0; k < 3; k++)
      steps.push_back(make_step(K_OVL, x10[k], p10[k], cram_val[p10[k]]));
    // line 11 overlay then hide it mid line 10
    steps.push_back(make_step(K_WAIT, 10, H_PIX_BEG, 0));
    for (k = 0; k < 3; k++)
      steps.push_back(make_step(K_OVL, x11[k], p11[k], border_rgb));
    steps.push_back(make_step(K_PORT, PORT_VCONF, 1 << VCONF_NOTSU_BIT, 0));
    // rest of line 10 keeps the old config
    for (k = 0; k < 3; k++)
      steps.push_back(make_step(K_PIX, H_PIX_BEG + x10[k], 0, cram_val[p10[k]]));
    steps.push_back(make_step(K_LINE, 11, 0, border_rgb));
  endtask

  initial
  begin
    int n;
    int i;
    int j;
    void'($urandom(SEED));
    rst      = 1'b1;
    port_wr  = '0;
    cram_wr  = '0;
    ts_wr    = '0;
    locked   = 1'b0;
    hsync_q  = 1'b0;
    vsync_q  = 1'b0;
    ox       = 0;
    oy       = 0;
    for (i = 0; i < 256; i++)
      cram_has[i] = 1'b0;
    for (i = 0; i < V_TOTAL; i++)
      for (j = 0; j < LINE_PIXELS; j++)
        ovl_set[i][j] = 1'b0;
    build_table();

    repeat (RST_CYCLES)
    begin
      tick();
      check_reset_state();
    end
    rst = 1'b0;
    // pipeline still empty
    repeat (3)
    begin
      tick();
      check_reset_state();
    end

    n = 0;
    while (!locked)
    begin
      tick();
      n++;
      if (n > FRAME_CLKS)
      begin
        $display("no vsync after reset");
        abort_run();
      end
    end
    // first position lands 4 clocks after release
    check_value("cycles to first vsync", n, 1);

    foreach (steps[k])
      apply_step(steps[k]);

    $display("Everything OK");
    $finish;
  end

endmodule

//--- verilog.f
logic/video_regs_pkg.sv
logic/video_raster_pkg.sv
logic/video_ports.sv
logic/video_raster.sv
logic/video_dpram.sv
logic/video_tsline.sv
logic/video_mixer.sv
logic/video_palette.sv
logic/video_top.sv
verification/video_top_tb.sv
